/* hdl/rv_decode_config.svh */
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// datapath width
`define RV_XLEN 32

// integer register file geometry
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// link value is pc plus one instruction
`define RV_LINK_OFFSET 4

`endif

/* hdl/rv_decode_pkg.sv */
`include "rv_decode_config.svh"

package rv_decode_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

	// major opcodes kept by the decoder
	typedef enum logic [6:0] {
		opc_load   = 7'b0000011,
		opc_op_imm = 7'b0010011,
		opc_auipc  = 7'b0010111,
		opc_store  = 7'b0100011,
		opc_op     = 7'b0110011,
		opc_lui    = 7'b0110111,
		opc_branch = 7'b1100011,
		opc_jalr   = 7'b1100111,
		opc_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_func_e;

	typedef enum logic [1:0] {
		a_sel_reg,
		a_sel_pc,
		a_sel_zero
	} alu_a_sel_e;

	typedef enum logic [1:0] {
		b_sel_reg,
		b_sel_imm
	} alu_b_sel_e;

	typedef enum logic [3:0] {
		mem_none,
		mem_lb,
		mem_lbu,
		mem_lh,
		mem_lhu,
		mem_lw,
		mem_sb,
		mem_sh,
		mem_sw
	} mem_rw_e;

	// valE from alu, valM from memory, valP is the link value
	typedef enum logic [1:0] {
		wb_val_e,
		wb_val_m,
		wb_val_p
	} wb_sel_e;

	typedef enum logic [2:0] {
		br_none,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_bltu,
		br_bgeu,
		br_always
	} br_op_e;

	typedef struct packed {
		alu_a_sel_e alu_a_sel;
		alu_b_sel_e alu_b_sel;
		alu_func_e  alu_func;
		mem_rw_e    mem_rw;
		logic       wb_reg_wen;
		reg_idx_t   wb_rd;
		wb_sel_e    wb_val_sel;
		br_op_e     br_op;
		logic       is_jalr;
	} ctrl_t;

	// no side effects, used for bubbles and unknown opcodes
	localparam ctrl_t ctrl_nop = '{
		alu_a_sel:  a_sel_reg,
		alu_b_sel:  b_sel_imm,
		alu_func:   alu_add,
		mem_rw:     mem_none,
		wb_reg_wen: 1'b0,
		wb_rd:      '0,
		wb_val_sel: wb_val_e,
		br_op:      br_none,
		is_jalr:    1'b0
	};

endpackage

/* hdl/decode_bus_if.sv */
`timescale 1ns/1ps

interface decode_bus_if;
	import rv_decode_pkg::*;

	logic     valid;
	ctrl_t    ctrl;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    imm;

	modport producer (
		output valid,
		output ctrl,
		output rs1,
		output rs2,
		output imm
	);

	modport consumer (
		input valid,
		input ctrl,
		input rs1,
		input rs2,
		input imm
	);

endinterface

/* hdl/bypass_src_if.sv */
`timescale 1ns/1ps

interface bypass_src_if;
	import rv_decode_pkg::*;

	logic     wen;
	reg_idx_t rd;
	wb_sel_e  val_sel;
	word_t    val_e;
	word_t    val_m;
	word_t    pc;

	modport source (
		output wen,
		output rd,
		output val_sel,
		output val_e,
		output val_m,
		output pc
	);

	modport sink (
		input wen,
		input rd,
		input val_sel,
		input val_e,
		input val_m,
		input pc
	);

endinterface

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rv_decode_pkg::word_t instr,
	input  logic                 instr_valid,
	decode_bus_if.producer       bus
);
	import rv_decode_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       is_shift;
	alu_func_e  alu_fn;
	ctrl_t      ctrl_d;
	reg_idx_t   rs1_d;
	reg_idx_t   rs2_d;
	word_t      imm_d;
	word_t      imm_i;
	word_t      imm_shamt;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm_u;

	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i     = {{20{instr[31]}}, instr[31:20]};
	assign imm_shamt = {27'd0, instr[24:20]};
	assign imm_s     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u     = {instr[31:12], 12'd0};

	// slli, srli and srai take shamt instead of the I immediate
	assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

	// shared by OP and OP-IMM, sub only exists in OP
	always_comb begin
		case (funct3)
			3'b000: alu_fn = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
			3'b001: alu_fn = alu_sll;
			3'b010: alu_fn = alu_slt;
			3'b011: alu_fn = alu_sltu;
			3'b100: alu_fn = alu_xor;
			3'b101: alu_fn = funct7[5] ? alu_sra : alu_srl;
			3'b110: alu_fn = alu_or;
			default: alu_fn = alu_and;
		endcase
	end

	always_comb begin
		ctrl_d = ctrl_nop;
		ctrl_d.wb_rd = instr[11:7];
		rs1_d = instr[19:15];
		rs2_d = instr[24:20];
		imm_d = '0;
		case (opcode)
			opc_op_imm: begin
				ctrl_d.alu_func = alu_fn;
				ctrl_d.wb_reg_wen = 1'b1;
				rs2_d = '0;
				imm_d = is_shift ? imm_shamt : imm_i;
			end
			opc_op: begin
				ctrl_d.alu_b_sel = b_sel_reg;
				ctrl_d.alu_func = alu_fn;
				ctrl_d.wb_reg_wen = 1'b1;
			end
			opc_load: begin
				ctrl_d.wb_reg_wen = 1'b1;
				ctrl_d.wb_val_sel = wb_val_m;
				rs2_d = '0;
				imm_d = imm_i;
				case (funct3)
					3'b000: ctrl_d.mem_rw = mem_lb;
					3'b001: ctrl_d.mem_rw = mem_lh;
					3'b010: ctrl_d.mem_rw = mem_lw;
					3'b100: ctrl_d.mem_rw = mem_lbu;
					3'b101: ctrl_d.mem_rw = mem_lhu;
					default: ctrl_d.mem_rw = mem_none;
				endcase
			end
			opc_store: begin
				imm_d = imm_s;
				case (funct3)
					3'b000: ctrl_d.mem_rw = mem_sb;
					3'b001: ctrl_d.mem_rw = mem_sh;
					3'b010: ctrl_d.mem_rw = mem_sw;
					default: ctrl_d.mem_rw = mem_none;
				endcase
			end
			opc_branch: begin
				ctrl_d.alu_a_sel = a_sel_pc;
				imm_d = imm_b;
				case (funct3)
					3'b000: ctrl_d.br_op = br_beq;
					3'b001: ctrl_d.br_op = br_bne;
					3'b100: ctrl_d.br_op = br_blt;
					3'b101: ctrl_d.br_op = br_bge;
					3'b110: ctrl_d.br_op = br_bltu;
					3'b111: ctrl_d.br_op = br_bgeu;
					default: ctrl_d.br_op = br_none;
				endcase
			end
			opc_jalr: begin
				ctrl_d.wb_reg_wen = 1'b1;
				ctrl_d.wb_val_sel = wb_val_p;
				ctrl_d.br_op = br_always;
				ctrl_d.is_jalr = 1'b1;
				rs2_d = '0;
				imm_d = imm_i;
			end
			opc_jal: begin
				ctrl_d.alu_a_sel = a_sel_pc;
				ctrl_d.wb_reg_wen = 1'b1;
				ctrl_d.wb_val_sel = wb_val_p;
				ctrl_d.br_op = br_always;
				rs1_d = '0;
				rs2_d = '0;
				imm_d = imm_j;
			end
			opc_lui: begin
				ctrl_d.alu_a_sel = a_sel_zero;
				ctrl_d.wb_reg_wen = 1'b1;
				rs1_d = '0;
				rs2_d = '0;
				imm_d = imm_u;
			end
			opc_auipc: begin
				ctrl_d.alu_a_sel = a_sel_pc;
				ctrl_d.wb_reg_wen = 1'b1;
				rs1_d = '0;
				rs2_d = '0;
				imm_d = imm_u;
			end
			default: begin
				// unknown opcode reads nothing
				rs1_d = '0;
				rs2_d = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus.valid <= 1'b0;
			bus.ctrl <= ctrl_nop;
		end else begin
			bus.valid <= instr_valid;
			bus.ctrl <= instr_valid ? ctrl_d : ctrl_nop;
		end
	end

	always_ff @(posedge clk) begin
		bus.rs1 <= rs1_d;
		bus.rs2 <= rs2_d;
		bus.imm <= imm_d;
	end

	wen_opcode_chk: assert property (@(posedge clk) disable iff (!rst_n)
		bus.valid && bus.ctrl.wb_reg_wen |->
			$past(instr[6:0]) inside {opc_op, opc_op_imm, opc_load, opc_jalr,
				opc_jal, opc_lui, opc_auipc});

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wr_en,
	input  rv_decode_pkg::reg_idx_t wr_idx,
	input  rv_decode_pkg::word_t    wr_data,
	input  rv_decode_pkg::reg_idx_t rd_idx_a,
	input  rv_decode_pkg::reg_idx_t rd_idx_b,
	output rv_decode_pkg::word_t    rd_data_a,
	output rv_decode_pkg::word_t    rd_data_b
);
	import rv_decode_pkg::*;

	word_t regs [`RV_REG_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// x0 is hardwired
	assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
	assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

	x0_zero_chk: assert property (@(posedge clk) disable iff (!rst_n)
		regs[0] == '0);

endmodule

/* hdl/operand_stage.sv */
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module operand_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ex_wen,
	input  rv_decode_pkg::reg_idx_t ex_rd,
	input  rv_decode_pkg::word_t    ex_val,
	input  rv_decode_pkg::word_t    rf_data_a,
	input  rv_decode_pkg::word_t    rf_data_b,
	decode_bus_if.consumer          bus,
	bypass_src_if.sink              mem_src,
	bypass_src_if.sink              wb_src,
	output rv_decode_pkg::reg_idx_t rf_idx_a,
	output rv_decode_pkg::reg_idx_t rf_idx_b,
	output logic                    out_valid,
	output rv_decode_pkg::word_t    val_a,
	output rv_decode_pkg::word_t    val_b,
	output rv_decode_pkg::word_t    imm,
	output rv_decode_pkg::ctrl_t    ctrl,
	output rv_decode_pkg::reg_idx_t rs1,
	output rv_decode_pkg::reg_idx_t rs2,
	output logic                    need_jump
);
	import rv_decode_pkg::*;

	word_t mem_fwd;
	word_t wb_fwd;
	word_t opnd_a;
	word_t opnd_b;
	logic  taken;

	function automatic logic src_hit(logic wen, reg_idx_t rd, reg_idx_t idx);
		return wen && (rd != '0) && (rd == idx);
	endfunction

	function automatic word_t src_value(wb_sel_e sel, word_t v_e, word_t v_m, word_t pc);
		case (sel)
			wb_val_m: return v_m;
			wb_val_p: return pc + `RV_LINK_OFFSET;
			default: return v_e;
		endcase
	endfunction

	// youngest producer wins
	function automatic word_t pick(reg_idx_t idx, word_t rf_val);
		if (src_hit(ex_wen, ex_rd, idx))
			return ex_val;
		if (src_hit(mem_src.wen, mem_src.rd, idx))
			return mem_fwd;
		if (src_hit(wb_src.wen, wb_src.rd, idx))
			return wb_fwd;
		return rf_val;
	endfunction

	assign rf_idx_a = bus.rs1;
	assign rf_idx_b = bus.rs2;

	assign mem_fwd = src_value(mem_src.val_sel, mem_src.val_e, mem_src.val_m, mem_src.pc);
	assign wb_fwd = src_value(wb_src.val_sel, wb_src.val_e, wb_src.val_m, wb_src.pc);

	always_comb begin
		opnd_a = pick(bus.rs1, rf_data_a);
		opnd_b = pick(bus.rs2, rf_data_b);
	end

	always_comb begin
		case (bus.ctrl.br_op)
			br_beq: taken = (opnd_a == opnd_b);
			br_bne: taken = (opnd_a != opnd_b);
			br_blt: taken = ($signed(opnd_a) < $signed(opnd_b));
			br_bge: taken = ($signed(opnd_a) >= $signed(opnd_b));
			br_bltu: taken = (opnd_a < opnd_b);
			br_bgeu: taken = (opnd_a >= opnd_b);
			br_always: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			ctrl <= ctrl_nop;
			need_jump <= 1'b0;
		end else begin
			out_valid <= bus.valid;
			ctrl <= bus.ctrl;
			need_jump <= bus.valid && taken;
		end
	end

	always_ff @(posedge clk) begin
		val_a <= opnd_a;
		val_b <= opnd_b;
		imm <= bus.imm;
		rs1 <= bus.rs1;
		rs2 <= bus.rs2;
	end

	jump_qual_chk: assert property (@(posedge clk) disable iff (!rst_n)
		need_jump |-> out_valid && (ctrl.br_op != br_none));

endmodule

/* hdl/rv_decode_top.sv */
`timescale 1ns/1ps

module rv_decode_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  rv_decode_pkg::word_t        instr,
	input  logic                        instr_valid,
	input  logic                        ex_wen,
	input  rv_decode_pkg::reg_idx_t     ex_rd,
	input  rv_decode_pkg::word_t        ex_val,
	input  logic                        mem_wen,
	input  rv_decode_pkg::reg_idx_t     mem_rd,
	input  rv_decode_pkg::wb_sel_e      mem_val_sel,
	input  rv_decode_pkg::word_t        mem_val_e,
	input  rv_decode_pkg::word_t        mem_val_m,
	input  rv_decode_pkg::word_t        mem_pc,
	input  logic                        wb_src_wen,
	input  rv_decode_pkg::reg_idx_t     wb_src_rd,
	input  rv_decode_pkg::wb_sel_e      wb_src_val_sel,
	input  rv_decode_pkg::word_t        wb_src_val_e,
	input  rv_decode_pkg::word_t        wb_src_val_m,
	input  rv_decode_pkg::word_t        wb_src_pc,
	input  logic                        wb_wen,
	input  rv_decode_pkg::reg_idx_t     wb_rd,
	input  rv_decode_pkg::word_t        wb_data,
	output logic                        out_valid,
	output rv_decode_pkg::word_t        val_a,
	output rv_decode_pkg::word_t        val_b,
	output rv_decode_pkg::word_t        imm,
	output rv_decode_pkg::alu_a_sel_e   alu_a_sel,
	output rv_decode_pkg::alu_b_sel_e   alu_b_sel,
	output rv_decode_pkg::alu_func_e    alu_func,
	output rv_decode_pkg::mem_rw_e      mem_rw,
	output logic                        wb_reg_wen,
	output rv_decode_pkg::reg_idx_t     wb_rd_out,
	output rv_decode_pkg::wb_sel_e      wb_val_sel,
	output rv_decode_pkg::reg_idx_t     rs1,
	output rv_decode_pkg::reg_idx_t     rs2,
	output logic                        need_jump,
	output logic                        is_jalr
);
	import rv_decode_pkg::*;

	reg_idx_t rf_idx_a;
	reg_idx_t rf_idx_b;
	word_t    rf_data_a;
	word_t    rf_data_b;
	ctrl_t    ctrl;

	decode_bus_if dec_bus ();
	bypass_src_if mem_src ();
	bypass_src_if wb_src ();

	assign mem_src.wen = mem_wen;
	assign mem_src.rd = mem_rd;
	assign mem_src.val_sel = mem_val_sel;
	assign mem_src.val_e = mem_val_e;
	assign mem_src.val_m = mem_val_m;
	assign mem_src.pc = mem_pc;

	assign wb_src.wen = wb_src_wen;
	assign wb_src.rd = wb_src_rd;
	assign wb_src.val_sel = wb_src_val_sel;
	assign wb_src.val_e = wb_src_val_e;
	assign wb_src.val_m = wb_src_val_m;
	assign wb_src.pc = wb_src_pc;

	instr_decoder instr_decoder_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.bus         (dec_bus.producer)
	);

	reg_file reg_file_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wb_wen),
		.wr_idx    (wb_rd),
		.wr_data   (wb_data),
		.rd_idx_a  (rf_idx_a),
		.rd_idx_b  (rf_idx_b),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b)
	);

	operand_stage operand_stage_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.ex_wen    (ex_wen),
		.ex_rd     (ex_rd),
		.ex_val    (ex_val),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.bus       (dec_bus.consumer),
		.mem_src   (mem_src.sink),
		.wb_src    (wb_src.sink),
		.rf_idx_a  (rf_idx_a),
		.rf_idx_b  (rf_idx_b),
		.out_valid (out_valid),
		.val_a     (val_a),
		.val_b     (val_b),
		.imm       (imm),
		.ctrl      (ctrl),
		.rs1       (rs1),
		.rs2       (rs2),
		.need_jump (need_jump)
	);

	// control struct onto plain ports
	assign alu_a_sel = ctrl.alu_a_sel;
	assign alu_b_sel = ctrl.alu_b_sel;
	assign alu_func = ctrl.alu_func;
	assign mem_rw = ctrl.mem_rw;
	assign wb_reg_wen = ctrl.wb_reg_wen;
	assign wb_rd_out = ctrl.wb_rd;
	assign wb_val_sel = ctrl.wb_val_sel;
	assign is_jalr = ctrl.is_jalr;

endmodule

/* test/tb_rv_decode.sv */
`timescale 1ns/1ps

module tb_rv_decode;
	import rv_decode_pkg::*;

	// rough cycle budget per test for the watchdog
	localparam int reset_cycles = 10;
	localparam int decode_cycles = 26 * 3;
	localparam int rf_cycles = 8 * 2 + 8 * 3 + 4;
	localparam int bypass_cycles = 12 * 3;
	localparam int branch_cycles = 34 * 7;
	localparam int stream_cycles = 30;
	localparam int total_cycles = reset_cycles + decode_cycles + rf_cycles
		+ bypass_cycles + branch_cycles + stream_cycles;

	logic clk;
	logic rst_n;
	word_t instr;
	logic instr_valid;
	logic ex_wen;
	reg_idx_t ex_rd;
	word_t ex_val;
	logic mem_wen;
	reg_idx_t mem_rd;
	wb_sel_e mem_val_sel;
	word_t mem_val_e;
	word_t mem_val_m;
	word_t mem_pc;
	logic wb_src_wen;
	reg_idx_t wb_src_rd;
	wb_sel_e wb_src_val_sel;
	word_t wb_src_val_e;
	word_t wb_src_val_m;
	word_t wb_src_pc;
	logic wb_wen;
	reg_idx_t wb_rd;
	word_t wb_data;
	logic out_valid;
	word_t val_a;
	word_t val_b;
	word_t imm;
	alu_a_sel_e alu_a_sel;
	alu_b_sel_e alu_b_sel;
	alu_func_e alu_func;
	mem_rw_e mem_rw;
	logic wb_reg_wen;
	reg_idx_t wb_rd_out;
	wb_sel_e wb_val_sel;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic need_jump;
	logic is_jalr;

	int fail_count = 0;
	int pass_count = 0;
	word_t rng_state = 32'h4891;
	word_t ref_regs [32];

	rv_decode_top rv_decode_top_inst (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic word_t rand_word();
		word_t x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2_i, reg_idx_t rs1_i,
		logic [2:0] f3, reg_idx_t rd_i, logic [6:0] opc);
		return {f7, rs2_i, rs1_i, f3, rd_i, opc};
	endfunction

	function automatic word_t enc_i(word_t im, reg_idx_t rs1_i, logic [2:0] f3,
		reg_idx_t rd_i, logic [6:0] opc);
		return {im[11:0], rs1_i, f3, rd_i, opc};
	endfunction

	function automatic word_t enc_s(word_t im, reg_idx_t rs2_i, reg_idx_t rs1_i, logic [2:0] f3);
		return {im[11:5], rs2_i, rs1_i, f3, im[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(word_t im, reg_idx_t rs2_i, reg_idx_t rs1_i, logic [2:0] f3);
		return {im[12], im[10:5], rs2_i, rs1_i, f3, im[4:1], im[11], 7'b1100011};
	endfunction

	function automatic word_t enc_u(logic [19:0] hi, reg_idx_t rd_i, logic [6:0] opc);
		return {hi, rd_i, opc};
	endfunction

	function automatic word_t enc_j(word_t im, reg_idx_t rd_i);
		return {im[20], im[10:1], im[11], im[19:12], rd_i, 7'b1101111};
	endfunction

	// bypass priority is execute, memory, writeback, then the file
	function automatic word_t model_operand(reg_idx_t idx);
		if (idx == 5'd0)
			return '0;
		if (ex_wen && ex_rd == idx)
			return ex_val;
		if (mem_wen && mem_rd == idx)
			return (mem_val_sel == wb_val_m) ? mem_val_m :
				(mem_val_sel == wb_val_p) ? mem_pc + 32'd4 : mem_val_e;
		if (wb_src_wen && wb_src_rd == idx)
			return (wb_src_val_sel == wb_val_m) ? wb_src_val_m :
				(wb_src_val_sel == wb_val_p) ? wb_src_pc + 32'd4 : wb_src_val_e;
		return ref_regs[idx];
	endfunction

	function automatic logic model_taken(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_a_sel(string name, alu_a_sel_e got, alu_a_sel_e exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_b_sel(string name, alu_b_sel_e got, alu_b_sel_e exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_alu_func(string name, alu_func_e got, alu_func_e exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_mem_rw(string name, mem_rw_e got, mem_rw_e exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_wb_sel(string name, wb_sel_e got, wb_sel_e exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic report_test(string name, int fails_before);
		if (fail_count == fails_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d failed checks", name, fail_count - fails_before);
	endtask

	task automatic clear_bypass();
		ex_wen = 1'b0;
		ex_rd = '0;
		ex_val = '0;
		mem_wen = 1'b0;
		mem_rd = '0;
		mem_val_sel = wb_val_e;
		mem_val_e = '0;
		mem_val_m = '0;
		mem_pc = '0;
		wb_src_wen = 1'b0;
		wb_src_rd = '0;
		wb_src_val_sel = wb_val_e;
		wb_src_val_e = '0;
		wb_src_val_m = '0;
		wb_src_pc = '0;
	endtask

	// returns at the falling edge between decode and operand sampling
	task automatic send(word_t ins);
		@(negedge clk);
		instr = ins;
		instr_valid = 1'b1;
		@(negedge clk);
		instr_valid = 1'b0;
		instr = '0;
	endtask

	task automatic write_reg(reg_idx_t idx, word_t val);
		@(negedge clk);
		wb_wen = 1'b1;
		wb_rd = idx;
		wb_data = val;
		@(negedge clk);
		wb_wen = 1'b0;
		if (idx != 5'd0)
			ref_regs[idx] = val;
	endtask

	task automatic check_decode(string name, word_t ins, word_t e_imm, alu_a_sel_e e_a,
		alu_b_sel_e e_b, alu_func_e e_fn, mem_rw_e e_mem, logic e_wen, wb_sel_e e_wsel,
		reg_idx_t e_rd, reg_idx_t e_rs1, reg_idx_t e_rs2, logic e_jalr);
		send(ins);
		@(negedge clk);
		check_bit({name, " out_valid"}, out_valid, 1'b1);
		check_word({name, " imm"}, imm, e_imm);
		check_a_sel({name, " alu_a_sel"}, alu_a_sel, e_a);
		check_b_sel({name, " alu_b_sel"}, alu_b_sel, e_b);
		check_alu_func({name, " alu_func"}, alu_func, e_fn);
		check_mem_rw({name, " mem_rw"}, mem_rw, e_mem);
		check_bit({name, " wb_reg_wen"}, wb_reg_wen, e_wen);
		check_wb_sel({name, " wb_val_sel"}, wb_val_sel, e_wsel);
		if (e_wen)
			check_idx({name, " wb_rd_out"}, wb_rd_out, e_rd);
		check_idx({name, " rs1"}, rs1, e_rs1);
		check_idx({name, " rs2"}, rs2, e_rs2);
		check_bit({name, " is_jalr"}, is_jalr, e_jalr);
	endtask

	task automatic test_reset();
		int f0;
		f0 = fail_count;
		check_bit("reset out_valid", out_valid, 1'b0);
		check_bit("reset wb_reg_wen", wb_reg_wen, 1'b0);
		check_bit("reset need_jump", need_jump, 1'b0);
		check_mem_rw("reset mem_rw", mem_rw, mem_none);
		// valid item followed directly by a bubble
		@(negedge clk);
		instr = enc_i(32'h5, 5'd1, 3'd0, 5'd2, opc_op_imm);
		instr_valid = 1'b1;
		@(negedge clk);
		instr_valid = 1'b0;
		@(negedge clk);
		check_bit("item out_valid", out_valid, 1'b1);
		@(negedge clk);
		check_bit("bubble out_valid", out_valid, 1'b0);
		instr = '0;
		report_test("reset", f0);
	endtask

	task automatic test_decode();
		int f0;
		f0 = fail_count;
		check_decode("addi", enc_i(32'hFFFFFFFD, 5'd1, 3'd0, 5'd5, opc_op_imm), 32'hFFFFFFFD,
			a_sel_reg, b_sel_imm, alu_add, mem_none, 1'b1, wb_val_e, 5'd5, 5'd1, 5'd0, 1'b0);
		check_decode("slli", enc_i(32'h7, 5'd2, 3'd1, 5'd6, opc_op_imm), 32'h7,
			a_sel_reg, b_sel_imm, alu_sll, mem_none, 1'b1, wb_val_e, 5'd6, 5'd2, 5'd0, 1'b0);
		check_decode("srai", enc_i(32'h41F, 5'd3, 3'd5, 5'd7, opc_op_imm), 32'h1F,
			a_sel_reg, b_sel_imm, alu_sra, mem_none, 1'b1, wb_val_e, 5'd7, 5'd3, 5'd0, 1'b0);
		check_decode("srli", enc_i(32'h4, 5'd3, 3'd5, 5'd7, opc_op_imm), 32'h4,
			a_sel_reg, b_sel_imm, alu_srl, mem_none, 1'b1, wb_val_e, 5'd7, 5'd3, 5'd0, 1'b0);
		check_decode("sltiu", enc_i(32'h7FF, 5'd4, 3'd3, 5'd8, opc_op_imm), 32'h7FF,
			a_sel_reg, b_sel_imm, alu_sltu, mem_none, 1'b1, wb_val_e, 5'd8, 5'd4, 5'd0, 1'b0);
		check_decode("andi", enc_i(32'hFFFFFF00, 5'd4, 3'd7, 5'd9, opc_op_imm), 32'hFFFFFF00,
			a_sel_reg, b_sel_imm, alu_and, mem_none, 1'b1, wb_val_e, 5'd9, 5'd4, 5'd0, 1'b0);
		check_decode("sub", enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd9, opc_op), 32'h0,
			a_sel_reg, b_sel_reg, alu_sub, mem_none, 1'b1, wb_val_e, 5'd9, 5'd1, 5'd2, 1'b0);
		check_decode("add", enc_r(7'h00, 5'd4, 5'd3, 3'd0, 5'd10, opc_op), 32'h0,
			a_sel_reg, b_sel_reg, alu_add, mem_none, 1'b1, wb_val_e, 5'd10, 5'd3, 5'd4, 1'b0);
		check_decode("sltu", enc_r(7'h00, 5'd6, 5'd5, 3'd3, 5'd11, opc_op), 32'h0,
			a_sel_reg, b_sel_reg, alu_sltu, mem_none, 1'b1, wb_val_e, 5'd11, 5'd5, 5'd6, 1'b0);
		check_decode("sra", enc_r(7'h20, 5'd8, 5'd7, 3'd5, 5'd12, opc_op), 32'h0,
			a_sel_reg, b_sel_reg, alu_sra, mem_none, 1'b1, wb_val_e, 5'd12, 5'd7, 5'd8, 1'b0);
		check_decode("or", enc_r(7'h00, 5'd10, 5'd9, 3'd6, 5'd13, opc_op), 32'h0,
			a_sel_reg, b_sel_reg, alu_or, mem_none, 1'b1, wb_val_e, 5'd13, 5'd9, 5'd10, 1'b0);
		check_decode("lb", enc_i(32'hFFFFFFF8, 5'd2, 3'd0, 5'd14, opc_load), 32'hFFFFFFF8,
			a_sel_reg, b_sel_imm, alu_add, mem_lb, 1'b1, wb_val_m, 5'd14, 5'd2, 5'd0, 1'b0);
		check_decode("lh", enc_i(32'h10, 5'd2, 3'd1, 5'd15, opc_load), 32'h10,
			a_sel_reg, b_sel_imm, alu_add, mem_lh, 1'b1, wb_val_m, 5'd15, 5'd2, 5'd0, 1'b0);
		check_decode("lw", enc_i(32'h7F0, 5'd3, 3'd2, 5'd16, opc_load), 32'h7F0,
			a_sel_reg, b_sel_imm, alu_add, mem_lw, 1'b1, wb_val_m, 5'd16, 5'd3, 5'd0, 1'b0);
		check_decode("lbu", enc_i(32'hFFFFF800, 5'd4, 3'd4, 5'd17, opc_load), 32'hFFFFF800,
			a_sel_reg, b_sel_imm, alu_add, mem_lbu, 1'b1, wb_val_m, 5'd17, 5'd4, 5'd0, 1'b0);
		check_decode("lhu", enc_i(32'h2, 5'd5, 3'd5, 5'd18, opc_load), 32'h2,
			a_sel_reg, b_sel_imm, alu_add, mem_lhu, 1'b1, wb_val_m, 5'd18, 5'd5, 5'd0, 1'b0);
		check_decode("sb", enc_s(32'hFFFFFFEC, 5'd3, 5'd2, 3'd0), 32'hFFFFFFEC,
			a_sel_reg, b_sel_imm, alu_add, mem_sb, 1'b0, wb_val_e, 5'd0, 5'd2, 5'd3, 1'b0);
		check_decode("sh", enc_s(32'h7FC, 5'd6, 5'd7, 3'd1), 32'h7FC,
			a_sel_reg, b_sel_imm, alu_add, mem_sh, 1'b0, wb_val_e, 5'd0, 5'd7, 5'd6, 1'b0);
		check_decode("sw", enc_s(32'h0, 5'd31, 5'd30, 3'd2), 32'h0,
			a_sel_reg, b_sel_imm, alu_add, mem_sw, 1'b0, wb_val_e, 5'd0, 5'd30, 5'd31, 1'b0);
		check_decode("beq", enc_b(32'hFFFFFFF0, 5'd2, 5'd1, 3'd0), 32'hFFFFFFF0,
			a_sel_pc, b_sel_imm, alu_add, mem_none, 1'b0, wb_val_e, 5'd0, 5'd1, 5'd2, 1'b0);
		check_decode("bgeu", enc_b(32'hFFE, 5'd4, 5'd3, 3'd7), 32'hFFE,
			a_sel_pc, b_sel_imm, alu_add, mem_none, 1'b0, wb_val_e, 5'd0, 5'd3, 5'd4, 1'b0);
		check_decode("jal", enc_j(32'h00012346, 5'd1), 32'h00012346,
			a_sel_pc, b_sel_imm, alu_add, mem_none, 1'b1, wb_val_p, 5'd1, 5'd0, 5'd0, 1'b0);
		check_decode("jal back", enc_j(32'hFFF00000, 5'd2), 32'hFFF00000,
			a_sel_pc, b_sel_imm, alu_add, mem_none, 1'b1, wb_val_p, 5'd2, 5'd0, 5'd0, 1'b0);
		check_decode("jalr", enc_i(32'hC, 5'd5, 3'd0, 5'd1, opc_jalr), 32'hC,
			a_sel_reg, b_sel_imm, alu_add, mem_none, 1'b1, wb_val_p, 5'd1, 5'd5, 5'd0, 1'b1);
		check_decode("lui", enc_u(20'hABCDE, 5'd3, opc_lui), 32'hABCDE000,
			a_sel_zero, b_sel_imm, alu_add, mem_none, 1'b1, wb_val_e, 5'd3, 5'd0, 5'd0, 1'b0);
		check_decode("auipc", enc_u(20'h80001, 5'd4, opc_auipc), 32'h80001000,
			a_sel_pc, b_sel_imm, alu_add, mem_none, 1'b1, wb_val_e, 5'd4, 5'd0, 5'd0, 1'b0);
		report_test("decode", f0);
	endtask

	task automatic read_check(reg_idx_t ra, reg_idx_t rb);
		send(enc_r(7'h00, rb, ra, 3'd0, 5'd3, opc_op));
		@(negedge clk);
		check_word("val_a", val_a, ra == 5'd0 ? 32'h0 : ref_regs[ra]);
		check_word("val_b", val_b, rb == 5'd0 ? 32'h0 : ref_regs[rb]);
	endtask

	task automatic test_reg_file();
		int f0;
		word_t old_val;
		word_t new_val;
		f0 = fail_count;
		write_reg(5'd1, rand_word());
		write_reg(5'd5, rand_word());
		write_reg(5'd12, rand_word());
		write_reg(5'd20, rand_word());
		write_reg(5'd31, rand_word());
		write_reg(5'd17, rand_word());
		write_reg(5'd2, rand_word());
		write_reg(5'd0, rand_word());
		read_check(5'd1, 5'd5);
		read_check(5'd12, 5'd20);
		read_check(5'd31, 5'd17);
		read_check(5'd0, 5'd2);
		read_check(5'd5, 5'd0);
		// write lands on the operand sampling edge
		old_val = ref_regs[12];
		new_val = rand_word();
		send(enc_r(7'h00, 5'd20, 5'd12, 3'd0, 5'd3, opc_op));
		wb_wen = 1'b1;
		wb_rd = 5'd12;
		wb_data = new_val;
		@(negedge clk);
		wb_wen = 1'b0;
		check_word("same cycle val_a", val_a, old_val);
		ref_regs[12] = new_val;
		read_check(5'd12, 5'd20);
		report_test("reg_file", f0);
	endtask

	task automatic bypass_case(string name, logic e_on, logic m_on, wb_sel_e m_sel,
		logic w_on, wb_sel_e w_sel, reg_idx_t src_rd, reg_idx_t rs);
		word_t exp;
		send(enc_r(7'h00, rs, rs, 3'd0, 5'd1, opc_op));
		ex_wen = e_on;
		ex_rd = src_rd;
		ex_val = rand_word();
		mem_wen = m_on;
		mem_rd = src_rd;
		mem_val_sel = m_sel;
		mem_val_e = rand_word();
		mem_val_m = rand_word();
		mem_pc = rand_word();
		wb_src_wen = w_on;
		wb_src_rd = src_rd;
		wb_src_val_sel = w_sel;
		wb_src_val_e = rand_word();
		wb_src_val_m = rand_word();
		wb_src_pc = rand_word();
		exp = model_operand(rs);
		@(negedge clk);
		check_word({name, " val_a"}, val_a, exp);
		check_word({name, " val_b"}, val_b, exp);
		clear_bypass();
	endtask

	task automatic test_bypass();
		int f0;
		f0 = fail_count;
		write_reg(5'd7, rand_word());
		bypass_case("ex first", 1'b1, 1'b1, wb_val_e, 1'b1, wb_val_e, 5'd7, 5'd7);
		bypass_case("mem val_e", 1'b0, 1'b1, wb_val_e, 1'b1, wb_val_m, 5'd7, 5'd7);
		bypass_case("mem val_m", 1'b0, 1'b1, wb_val_m, 1'b1, wb_val_e, 5'd7, 5'd7);
		bypass_case("mem link", 1'b0, 1'b1, wb_val_p, 1'b1, wb_val_e, 5'd7, 5'd7);
		bypass_case("wb val_e", 1'b0, 1'b0, wb_val_m, 1'b1, wb_val_e, 5'd7, 5'd7);
		bypass_case("wb val_m", 1'b0, 1'b0, wb_val_e, 1'b1, wb_val_m, 5'd7, 5'd7);
		bypass_case("wb link", 1'b0, 1'b0, wb_val_e, 1'b1, wb_val_p, 5'd7, 5'd7);
		bypass_case("file", 1'b0, 1'b0, wb_val_e, 1'b0, wb_val_e, 5'd7, 5'd7);
		bypass_case("rd zero", 1'b1, 1'b1, wb_val_e, 1'b1, wb_val_e, 5'd0, 5'd0);
		bypass_case("wen low", 1'b0, 1'b0, wb_val_m, 1'b0, wb_val_p, 5'd7, 5'd7);
		bypass_case("rd other", 1'b1, 1'b1, wb_val_e, 1'b1, wb_val_e, 5'd8, 5'd7);
		report_test("bypass", f0);
	endtask

	task automatic branch_case(logic [2:0] f3, word_t a, word_t b);
		write_reg(5'd1, a);
		write_reg(5'd2, b);
		send(enc_b(32'h8, 5'd2, 5'd1, f3));
		@(negedge clk);
		check_bit("need_jump", need_jump, model_taken(f3, a, b));
	endtask

	task automatic jump_case(string name, word_t ins, logic exp);
		send(ins);
		@(negedge clk);
		check_bit({name, " need_jump"}, need_jump, exp);
	endtask

	task automatic test_branch();
		int f0;
		logic [2:0] ops [6];
		word_t r;
		f0 = fail_count;
		ops = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		foreach (ops[i]) begin
			r = rand_word();
			branch_case(ops[i], r, r);
			branch_case(ops[i], rand_word(), rand_word());
			branch_case(ops[i], 32'h80000000, 32'h1);
			branch_case(ops[i], 32'h1, 32'h80000000);
			branch_case(ops[i], 32'hFFFFFFFF, 32'h0);
		end
		jump_case("jal", enc_j(32'h100, 5'd1), 1'b1);
		jump_case("jalr", enc_i(32'h0, 5'd1, 3'd0, 5'd0, opc_jalr), 1'b1);
		jump_case("add", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, opc_op), 1'b0);
		jump_case("lui", enc_u(20'h12345, 5'd3, opc_lui), 1'b0);
		report_test("branch", f0);
	endtask

	task automatic test_stream();
		int f0;
		logic s_valid [24];
		word_t s_imm [24];
		reg_idx_t s_rd [24];
		word_t r;
		f0 = fail_count;
		for (int c = 0; c < 26; c++) begin
			@(negedge clk);
			if (c >= 2) begin
				check_bit("stream out_valid", out_valid, s_valid[c-2]);
				if (s_valid[c-2]) begin
					check_word("stream imm", imm, s_imm[c-2]);
					check_idx("stream wb_rd_out", wb_rd_out, s_rd[c-2]);
				end
			end
			if (c < 24) begin
				r = rand_word();
				s_valid[c] = r[0] | (c < 4);
				s_imm[c] = {21'd0, r[11:1]};
				s_rd[c] = r[20:16];
				instr = enc_i(s_imm[c], 5'd1, 3'd0, s_rd[c], opc_op_imm);
				instr_valid = s_valid[c];
			end else begin
				instr_valid = 1'b0;
			end
		end
		report_test("stream", f0);
	endtask

	initial begin
		#(total_cycles * 10 * 2);
		$display("timeout: the tests did not finish in the expected time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		wb_wen = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		clear_bypass();
		foreach (ref_regs[i])
			ref_regs[i] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_decode();
		test_reg_file();
		test_bypass();
		test_branch();
		test_stream();
		$display("checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hdl
hdl/rv_decode_pkg.sv
hdl/decode_bus_if.sv
hdl/bypass_src_if.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/operand_stage.sv
hdl/rv_decode_top.sv
test/tb_rv_decode.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_decode
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)
